// File: all.f
+incdir+.
IntExecTypes.sv
IntALU.sv
IntShifter.sv
IntExecPipeReg.sv
IntExecUnit.sv
IntExecUnit_chk.sv
IntExecUnit_tb.sv

// File: Makefile
# Verilator build and run for the integer execution stage testbench

SIM = obj_dir/VIntExecUnit_tb

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(wildcard *.sv) $(wildcard *.svh) all.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module IntExecUnit_tb -f all.f

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: IntExecUnit_tb.sv
// IntExecUnit_tb: clock, reset, directed and random stimulus, watchdog
// Result checking is done by the bound IntExecUnit_chk

module IntExecUnit_tb import IntExecTypes::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumDirected = 19;
    localparam int NumRandom = 300;
    localparam int NumOps = NumDirected + NumRandom;
    // Ten cycles per operation plus the reset phase
    localparam int TimeoutNs = (NumOps + 10) * 10 * 10;

    logic clk = 1'b0;
    logic rst;
    logic opValid;
    logic opReady;
    IntOpClass opClass;
    IntALU_Code aluCode;
    ShiftCode shiftCode;
    DataPath srcA;
    DataPath srcB;
    OpTag opTag;
    logic resValid;
    logic resReady = 1'b1;
    DataPath resData;
    OpTag resTag;

    int seed = 32'hf7cd;
    int failCount = 0;
    int doneCount = 0;
    OpTag nextTag = '0;

    IntExecUnit u_IntExecUnit (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .opReady(opReady),
        .opClass(opClass),
        .aluCode(aluCode),
        .shiftCode(shiftCode),
        .srcA(srcA),
        .srcB(srcB),
        .opTag(opTag),
        .resValid(resValid),
        .resReady(resReady),
        .resData(resData),
        .resTag(resTag)
    );

    bind IntExecUnit IntExecUnit_chk chk (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .opReady(opReady),
        .opClass(opClass),
        .aluCode(aluCode),
        .shiftCode(shiftCode),
        .srcA(srcA),
        .srcB(srcB),
        .opTag(opTag),
        .resValid(resValid),
        .resReady(resReady),
        .resData(resData),
        .resTag(resTag)
    );

    always #5 clk = ~clk;

    // Sink stalls about a third of the time
    always @(negedge clk) begin
        if (rst) begin
            resReady = 1'b1;
        end else begin
            resReady = ($unsigned($random(seed)) % 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (!rst && resValid && resReady) begin
            doneCount++;
        end
    end

    always @(u_IntExecUnit.chk.failEvt) begin
        failCount++;
        $display("Test failed");
        $fatal(1, "Assertion failure reported by the result checker");
    end

    initial begin
        #(TimeoutNs);
        $display("Test failed");
        $fatal(1, "Run timed out after %0d ns with %0d of %0d results", TimeoutNs,
               doneCount, NumOps);
    end

    // Drive one operation and hold it until the DUT takes it
    task automatic sendOp(input IntOpClass cls, input IntALU_Code ac, input ShiftCode sc,
                          input DataPath a, input DataPath b);
        logic taken;
        taken = 1'b0;
        @(negedge clk);
        opValid = 1'b1;
        opClass = cls;
        aluCode = ac;
        shiftCode = sc;
        srcA = a;
        srcB = b;
        opTag = nextTag;
        while (!taken) begin
            #1;
            taken = opReady;
            @(posedge clk);
            if (!taken) begin
                @(negedge clk);
            end
        end
        nextTag = nextTag + 1'b1;
    endtask

    initial begin
        DataPath rndA;
        DataPath rndB;
        IntOpClass rndCls;
        IntALU_Code rndAlu;
        ShiftCode rndShift;

        rst = 1'b1;
        opValid = 1'b0;
        opClass = OC_ALU;
        aluCode = AC_AND;
        shiftCode = SC_SLL;
        srcA = '0;
        srcB = '0;
        opTag = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Corner operands
        sendOp(OC_ALU, AC_ADD, SC_SLL, 32'hffffffff, 32'h1);
        sendOp(OC_ALU, AC_SUB, SC_SLL, 32'h0, 32'h1);
        sendOp(OC_ALU, AC_SUB, SC_SLL, 32'h80000000, 32'h1);
        sendOp(OC_ALU, AC_SLT, SC_SLL, 32'h80000000, 32'h0);
        sendOp(OC_ALU, AC_SLTU, SC_SLL, 32'h80000000, 32'h0);
        sendOp(OC_ALU, AC_SLT, SC_SLL, 32'h0, 32'hffffffff);
        sendOp(OC_ALU, AC_SLTU, SC_SLL, 32'h0, 32'hffffffff);
        sendOp(OC_ALU, AC_EQZ, SC_SLL, 32'h1234abcd, 32'h0);
        sendOp(OC_ALU, AC_EQZ, SC_SLL, 32'h1234abcd, 32'h5);
        sendOp(OC_ALU, AC_NEZ, SC_SLL, 32'h1234abcd, 32'h0);
        sendOp(OC_ALU, AC_NEZ, SC_SLL, 32'h1234abcd, 32'h5);
        sendOp(OC_ALU, AC_AND, SC_SLL, 32'hffffffff, 32'h80000000);
        sendOp(OC_ALU, AC_EOR, SC_SLL, 32'hffffffff, 32'h0);
        sendOp(OC_ALU, AC_ORR, SC_SLL, 32'h0, 32'h80000000);
        sendOp(OC_SHIFT, AC_AND, SC_SLL, 32'h1, 32'd31);
        sendOp(OC_SHIFT, AC_AND, SC_SRL, 32'h80000000, 32'd31);
        sendOp(OC_SHIFT, AC_AND, SC_SRA, 32'h80000000, 32'd31);
        // Upper bits of B must be ignored
        sendOp(OC_SHIFT, AC_AND, SC_SRA, 32'h80000000, 32'hffffffe4);
        sendOp(OC_SHIFT, AC_AND, SC_SLL, 32'hffffffff, 32'h0);

        for (int i = 0; i < NumRandom; i++) begin
            rndA = $random(seed);
            rndB = $random(seed);
            if (($unsigned($random(seed)) % 8) == 0) begin
                rndB = '0;
            end
            rndCls = IntOpClass'(1'($random(seed)));
            rndAlu = IntALU_Code'(4'($unsigned($random(seed)) % 9));
            rndShift = ShiftCode'(2'($unsigned($random(seed)) % 3));
            sendOp(rndCls, rndAlu, rndShift, rndA, rndB);
        end

        @(negedge clk);
        opValid = 1'b0;
        wait (doneCount == NumOps);
        @(negedge clk);
        if (failCount == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "%0d assertion failures", failCount);
        end
    end

endmodule : IntExecUnit_tb

// File: IntExecUnit_chk.sv
// IntExecUnit_chk: reference model and concurrent assertions for IntExecUnit
// Expected results are kept per tag, acceptance order in a small tag FIFO

`include "IntExec_cfg.svh"

module IntExecUnit_chk import IntExecTypes::*; (
    input logic clk,
    input logic rst,
    input logic opValid,
    input logic opReady,
    input IntOpClass opClass,
    input IntALU_Code aluCode,
    input ShiftCode shiftCode,
    input DataPath srcA,
    input DataPath srcB,
    input OpTag opTag,
    input logic resValid,
    input logic resReady,
    input DataPath resData,
    input OpTag resTag
);
    timeunit 1ns;
    timeprecision 1ps;

    event failEvt;

    DataPath expData [2**`TAG_WIDTH];
    OpTag orderQ [2**`TAG_WIDTH];
    OpTag wrPtr;
    OpTag rdPtr;
    int pendCount;
    logic inXfer;
    logic outXfer;

    function automatic DataPath refResult(input IntOpClass cls, input IntALU_Code ac,
                                          input ShiftCode sc, input DataPath a,
                                          input DataPath b);
        int sh;
        DataPath r;
        sh = int'(b[`SHAMT_WIDTH-1:0]);
        if (cls == OC_SHIFT) begin
            case (sc)
                SC_SRL:  r = a >> sh;
                // Zero shift then refill the vacated top bits with the sign
                SC_SRA:  r = (a >> sh) | (a[`DATA_WIDTH-1] ? ~({`DATA_WIDTH{1'b1}} >> sh) : '0);
                default: r = a << sh;
            endcase
        end else begin
            case (ac)
                AC_EOR:  r = a ^ b;
                AC_ORR:  r = a | b;
                AC_ADD:  r = a + b;
                AC_SUB:  r = a - b;
                AC_SLT:  r = DataPath'($signed(a) < $signed(b));
                AC_SLTU: r = DataPath'(a < b);
                AC_EQZ:  r = (b == 0) ? '0 : a;
                AC_NEZ:  r = (b != 0) ? '0 : a;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    assign inXfer = opValid && opReady;
    assign outXfer = resValid && resReady;

    always @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            pendCount <= 0;
        end else begin
            if (inXfer) begin
                expData[opTag] <= refResult(opClass, aluCode, shiftCode, srcA, srcB);
                orderQ[wrPtr] <= opTag;
                wrPtr <= wrPtr + 1'b1;
            end
            if (outXfer) begin
                rdPtr <= rdPtr + 1'b1;
            end
            pendCount <= pendCount + int'(inXfer) - int'(outXfer);
        end
    end

    aResultData: assert property (@(posedge clk) disable iff (rst)
        outXfer |-> resData == expData[resTag])
        else begin
            -> failEvt;
            $error("** Error at %0d ns: wrong result for tag %0d", $time, $sampled(resTag));
        end

    // Each result once, in acceptance order
    aResultOrder: assert property (@(posedge clk) disable iff (rst)
        outXfer |-> pendCount > 0 && resTag == orderQ[rdPtr])
        else begin
            -> failEvt;
            $error("** Error at %0d ns: tag %0d out of order or unexpected",
                   $time, $sampled(resTag));
        end

    aHoldStable: assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && $stable(resData) && $stable(resTag))
        else begin
            -> failEvt;
            $error("** Error at %0d ns: result changed while stalled", $time);
        end

    aLatency: assert property (@(posedge clk) disable iff (rst)
        $past(inXfer) && resReady |=> resValid && resTag == $past(opTag, 2))
        else begin
            -> failEvt;
            $error("** Error at %0d ns: result not valid two cycles after accept", $time);
        end

    aResetState: assert property (@(posedge clk)
        $fell(rst) |-> !resValid && opReady)
        else begin
            -> failEvt;
            $error("** Error at %0d ns: wrong handshake state after reset", $time);
        end

endmodule : IntExecUnit_chk

// File: IntExecUnit.sv
// IntExecUnit: integer execution stage top level
// Operand register, ALU and shifter, result register

module IntExecUnit import IntExecTypes::*; (
    input logic clk,
    input logic rst,

    // Operation in
    input logic opValid,
    output logic opReady,
    input IntOpClass opClass,
    input IntALU_Code aluCode,
    input ShiftCode shiftCode,
    input DataPath srcA,
    input DataPath srcB,
    input OpTag opTag,

    // Result out
    output logic resValid,
    input logic resReady,
    output DataPath resData,
    output OpTag resTag
);
    IntExecOp opIn;
    IntExecOp opOut;
    logic opOutValid;

    IntExecResult resIn;
    IntExecResult resOut;
    logic resInReady;

    DataPath aluData;
    DataPath shiftData;

    always_comb begin
        opIn.opClass = opClass;
        opIn.aluCode = aluCode;
        opIn.shiftCode = shiftCode;
        opIn.srcA = srcA;
        opIn.srcB = srcB;
        opIn.tag = opTag;
    end

    IntExecPipeReg #(.PayloadT(IntExecOp)) opStage (
        .clk(clk),
        .rst(rst),
        .inValid(opValid),
        .inReady(opReady),
        .inData(opIn),
        .outValid(opOutValid),
        .outReady(resInReady),
        .outData(opOut)
    );

    IntALU alu (
        .aluDataOut(aluData),
        .aluCode(opOut.aluCode),
        .fuOpA_In(opOut.srcA),
        .fuOpB_In(opOut.srcB)
    );

    IntShifter shifter (
        .shiftDataOut(shiftData),
        .shiftCode(opOut.shiftCode),
        .shiftOpA(opOut.srcA),
        .shiftOpB(opOut.srcB)
    );

    // Pick the unit by class, the tag rides along
    assign resIn.data = (opOut.opClass == OC_SHIFT) ? shiftData : aluData;
    assign resIn.tag = opOut.tag;

    IntExecPipeReg #(.PayloadT(IntExecResult)) resStage (
        .clk(clk),
        .rst(rst),
        .inValid(opOutValid),
        .inReady(resInReady),
        .inData(resIn),
        .outValid(resValid),
        .outReady(resReady),
        .outData(resOut)
    );

    assign resData = resOut.data;
    assign resTag = resOut.tag;

endmodule : IntExecUnit

// File: IntExecPipeReg.sv
// IntExecPipeReg: one-entry valid/ready pipeline register
// Payload type is a parameter so one module serves both stages

module IntExecPipeReg import IntExecTypes::*; #(
    parameter type PayloadT = IntExecResult
) (
    input logic clk,
    input logic rst,
    input logic inValid,
    output logic inReady,
    input PayloadT inData,
    output logic outValid,
    input logic outReady,
    output PayloadT outData
);
    logic full;
    PayloadT payload;

    // Take a new item when empty or when the held one leaves this cycle
    assign inReady = !full || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            payload <= inData;
        end
    end

    assign outValid = full;
    assign outData = payload;

endmodule : IntExecPipeReg

// File: IntShifter.sv
// IntShifter: combinational shifter for SLL, SRL and SRA
// Shift amount is taken from the low bits of operand B

`include "IntExec_cfg.svh"

module IntShifter import IntExecTypes::*; (
    output DataPath shiftDataOut,
    input ShiftCode shiftCode,
    input DataPath shiftOpA,
    input DataPath shiftOpB
);
    logic [`SHAMT_WIDTH-1:0] shamt;
    SignedDataPath signedOpA;

    // Upper bits of B are ignored
    assign shamt = shiftOpB[`SHAMT_WIDTH-1:0];
    assign signedOpA = shiftOpA;

    always_comb begin
        case (shiftCode)
            // Zero fill from the top
            SC_SRL:  shiftDataOut = shiftOpA >> shamt;
            // Sign fill from the top
            SC_SRA:  shiftDataOut = DataPath'(signedOpA >>> shamt);
            // SLL
            default: shiftDataOut = shiftOpA << shamt;
        endcase
    end

endmodule : IntShifter

// File: IntALU.sv
// IntAdder: adder with optional operand inversion and signed overflow
// IntALU: combinational integer ALU covering logic, add and subtract,
// signed and unsigned compare, and the conditional-zero operations

`include "IntExec_cfg.svh"

// Sum with carry out on top
typedef struct packed {
    logic carry;
    IntExecTypes::DataPath data;
} IntAdderResult;

module IntAdder import IntExecTypes::*; (
    output IntAdderResult dst,
    output logic overflowOut,
    input DataPath srcA,
    input logic invA,
    input DataPath srcB,
    input logic invB,
    input logic carryIn
);
    DataPath tmpA;
    DataPath tmpB;

    always_comb begin
        tmpA = invA ? ~srcA : srcA;
        tmpB = invB ? ~srcB : srcB;
        dst = {1'b0, tmpA} + {1'b0, tmpB} + {{`DATA_WIDTH{1'b0}}, carryIn};
        // Sum sign disagrees with both operand signs
        overflowOut = (dst.data[`DATA_WIDTH-1] ^ tmpA[`DATA_WIDTH-1]) &&
                      (dst.data[`DATA_WIDTH-1] ^ tmpB[`DATA_WIDTH-1]);
    end
endmodule : IntAdder


module IntALU import IntExecTypes::*; (
    output DataPath aluDataOut,
    input IntALU_Code aluCode,
    input DataPath fuOpA_In,
    input DataPath fuOpB_In
);
    IntAdderResult adderDst;
    DataPath adderInA;
    DataPath adderInB;
    logic adderInvInB;
    logic adderInCarry;
    logic adderOutOverflow;   // no flags in this core

    SignedDataPath signedOpA;
    SignedDataPath signedOpB;
    IntAdderResult opDst;

    IntAdder adder (
        .dst(adderDst),
        .overflowOut(adderOutOverflow),
        .srcA(adderInA),
        .invA(1'b0),
        .srcB(adderInB),
        .invB(adderInvInB),
        .carryIn(adderInCarry)
    );

    // Adder inputs stay at zero outside ADD and SUB
    always_comb begin
        adderInA = '0;
        adderInB = '0;
        adderInvInB = 1'b0;
        adderInCarry = 1'b0;
        if (aluCode == AC_ADD || aluCode == AC_SUB) begin
            adderInA = fuOpA_In;
            adderInB = fuOpB_In;
        end
        // a - b = a + ~b + 1
        if (aluCode == AC_SUB) begin
            adderInvInB = 1'b1;
            adderInCarry = 1'b1;
        end
    end

    assign signedOpA = fuOpA_In;
    assign signedOpB = fuOpB_In;

    // Result select
    always_comb begin
        case (aluCode)
            AC_EOR:  opDst = {1'b0, fuOpA_In ^ fuOpB_In};
            AC_SUB,
            AC_ADD:  opDst = adderDst;
            AC_SLT:  opDst = {1'b0, {(`DATA_WIDTH-1){1'b0}}, signedOpA < signedOpB};
            AC_SLTU: opDst = {1'b0, {(`DATA_WIDTH-1){1'b0}}, fuOpA_In < fuOpB_In};
            AC_ORR:  opDst = {1'b0, fuOpA_In | fuOpB_In};
            AC_EQZ:  opDst = {1'b0, (fuOpB_In == '0) ? '0 : fuOpA_In};
            AC_NEZ:  opDst = {1'b0, (fuOpB_In != '0) ? '0 : fuOpA_In};
            // AND
            default: opDst = {1'b0, fuOpA_In & fuOpB_In};
        endcase
    end

    assign aluDataOut = opDst.data;

endmodule : IntALU

// File: IntExecTypes.sv
// Types for the integer execution stage
// Data and tag words, opcode enums, operand and result payloads

`include "IntExec_cfg.svh"

package IntExecTypes;

    typedef logic [`DATA_WIDTH-1:0] DataPath;
    typedef logic signed [`DATA_WIDTH-1:0] SignedDataPath;
    typedef logic [`TAG_WIDTH-1:0] OpTag;

    // Which unit computes the result
    typedef enum logic {
        OC_ALU   = 1'b0,
        OC_SHIFT = 1'b1
    } IntOpClass;

    typedef enum logic [3:0] {
        AC_AND  = 4'h0,
        AC_EOR  = 4'h1,
        AC_SUB  = 4'h2,
        AC_ADD  = 4'h3,
        AC_SLT  = 4'h4,
        AC_SLTU = 4'h5,
        AC_ORR  = 4'h6,
        AC_EQZ  = 4'h7,   // czero.eqz
        AC_NEZ  = 4'h8    // czero.nez
    } IntALU_Code;

    typedef enum logic [1:0] {
        SC_SLL = 2'h0,
        SC_SRL = 2'h1,
        SC_SRA = 2'h2
    } ShiftCode;

    // Operand register payload
    typedef struct packed {
        IntOpClass  opClass;
        IntALU_Code aluCode;
        ShiftCode   shiftCode;
        DataPath    srcA;
        DataPath    srcB;
        OpTag       tag;
    } IntExecOp;

    // Result register payload
    typedef struct packed {
        DataPath data;
        OpTag    tag;
    } IntExecResult;

endpackage

// File: IntExec_cfg.svh
// Widths shared by the integer execution stage
// Data word, operation tag and shift amount

`ifndef INT_EXEC_CFG_SVH
`define INT_EXEC_CFG_SVH

// Operand and result width
`define DATA_WIDTH 32

// Tag carried alongside each operation
`define TAG_WIDTH 4

// Low bits of operand B used as shift amount
`define SHAMT_WIDTH 5

`endif
